//--- hw/decoder_pkg.sv
`default_nettype none

// Shared types of the union-find decoding graph

package decoder_pkg;

    // Global stage, broadcast to every unit and link
    typedef enum logic [1:0] {
        STAGE_IDLE  = 2'd0, // Everything holds
        STAGE_LOAD  = 2'd1, // Shift one measurement round in
        STAGE_GROW  = 2'd2, // Links grow toward occupied ends
        STAGE_MERGE = 2'd3  // Roots settle to the cluster minimum
    } stage_e;

    // Slot index of a neighbour inside the per-unit vectors
    typedef enum logic [2:0] {
        DIR_NORTH = 3'd0, // x - 1
        DIR_SOUTH = 3'd1, // x + 1
        DIR_WEST  = 3'd2, // z - 1
        DIR_EAST  = 3'd3, // z + 1
        DIR_DOWN  = 3'd4, // Previous round
        DIR_UP    = 3'd5  // Next round
    } neighbor_dir_e;

    localparam int NEIGHBOR_COUNT = 32'd6;

endpackage

`default_nettype wire

//--- hw/neighbor_link.sv
`timescale 1ns/100ps
`default_nettype none

// One weighted edge of the graph. The counter grows by one step per
// occupied endpoint and stops at MAX_WEIGHT.

module neighbor_link #(
    parameter int MAX_WEIGHT = 2
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire decoder_pkg::stage_e stage_i,
    input  wire                     a_occupied_i,
    input  wire                     b_occupied_i,
    output logic                    fully_grown_o
);

    localparam int COUNT_WIDTH = (MAX_WEIGHT > 1) ? $clog2(MAX_WEIGHT + 1) : 1;
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(MAX_WEIGHT);

    logic [COUNT_WIDTH-1:0] count_q;
    logic [1:0]             increase;
    logic [COUNT_WIDTH:0]   count_sum; // One spare bit so the sum cannot wrap
    logic [COUNT_WIDTH-1:0] count_next;

    // Zero, one or two steps per cycle
    assign increase = {1'b0, a_occupied_i} + {1'b0, b_occupied_i};

    assign count_sum = {1'b0, count_q} + (COUNT_WIDTH + 1)'(increase);

    always_comb begin
        if (count_sum >= {1'b0, FULL_COUNT}) begin
            count_next = FULL_COUNT; // Saturate at the edge weight
        end else begin
            count_next = count_sum[COUNT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            case (stage_i)
                decoder_pkg::STAGE_LOAD: begin
                    count_q <= '0; // New syndrome starts from bare edges
                end
                decoder_pkg::STAGE_GROW: begin
                    count_q <= count_next;
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

    assign fully_grown_o = (count_q == FULL_COUNT);

endmodule

`default_nettype wire

//--- hw/processing_unit.sv
`timescale 1ns/100ps
`default_nettype none

// One vertex of the decoding graph. Holds the defect bit of its position
// and the root address of the cluster it currently belongs to.

module processing_unit #(
    parameter int ADDRESS_WIDTH = 5,
    parameter int ADDRESS       = 0
) (
    input  wire                                                 clk,
    input  wire                                                 reset,
    input  wire decoder_pkg::stage_e                            stage_i,
    input  wire                                                 measurement_i,
    input  wire [decoder_pkg::NEIGHBOR_COUNT-1:0]               neighbor_fully_grown_i,
    input  wire [decoder_pkg::NEIGHBOR_COUNT*ADDRESS_WIDTH-1:0] neighbor_roots_i,
    output logic                                                defect_o,
    output logic                                                occupied_o,
    output logic [ADDRESS_WIDTH-1:0]                            root_o,
    output logic                                                busy_o
);

    localparam logic [ADDRESS_WIDTH-1:0] OWN_ADDRESS = ADDRESS_WIDTH'(ADDRESS);

    logic                     defect_q;
    logic [ADDRESS_WIDTH-1:0] root_q;
    logic                     busy_q;

    logic [ADDRESS_WIDTH-1:0] neighbor_root [decoder_pkg::NEIGHBOR_COUNT];
    logic [ADDRESS_WIDTH-1:0] merged_root;
    logic                     root_changed;

    genvar d;

    // Split the flat root bus into one address per direction slot
    generate
        for (d = 0; d < decoder_pkg::NEIGHBOR_COUNT; d = d + 1) begin : g_slot
            assign neighbor_root[d] = neighbor_roots_i[d*ADDRESS_WIDTH +: ADDRESS_WIDTH];
        end
    endgenerate

    // Smallest root reachable over a fully grown edge, own root included
    always_comb begin
        merged_root = root_q;
        for (int i = 0; i < decoder_pkg::NEIGHBOR_COUNT; i++) begin
            if (neighbor_fully_grown_i[i] && (neighbor_root[i] < merged_root)) begin
                merged_root = neighbor_root[i];
            end
        end
    end

    assign root_changed = (merged_root != root_q);

    // Syndrome bit, shifted down one round per load cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            defect_q <= 1'b0;
        end else if (stage_i == decoder_pkg::STAGE_LOAD) begin
            defect_q <= measurement_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root_q <= OWN_ADDRESS;
        end else begin
            case (stage_i)
                decoder_pkg::STAGE_LOAD: begin
                    root_q <= OWN_ADDRESS; // Every unit starts as its own cluster
                end
                decoder_pkg::STAGE_MERGE: begin
                    root_q <= merged_root;
                end
                default: begin
                    root_q <= root_q;
                end
            endcase
        end
    end

    // Busy follows a root change by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else begin
            case (stage_i)
                decoder_pkg::STAGE_MERGE: begin
                    busy_q <= root_changed;
                end
                decoder_pkg::STAGE_IDLE: begin
                    busy_q <= busy_q;
                end
                default: begin
                    busy_q <= 1'b0; // Load and grow never move a root
                end
            endcase
        end
    end

    // A fully grown edge pulls this unit into the cluster
    assign occupied_o = defect_q | (|neighbor_fully_grown_i);

    assign defect_o = defect_q;
    assign root_o   = root_q;
    assign busy_o   = busy_q;

endmodule

`default_nettype wire

//--- hw/decoding_graph.sv
`timescale 1ns/100ps
`default_nettype none

// Top of the union-find decoding graph: a GRID_WIDTH_X by GRID_WIDTH_Z
// plane of units per round, GRID_WIDTH_U rounds deep, with one link
// between every pair of adjacent units

module decoding_graph #(
    parameter int GRID_WIDTH_X = 4,
    parameter int GRID_WIDTH_Z = 1,
    parameter int GRID_WIDTH_U = 5,
    parameter int MAX_WEIGHT   = 2,

    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z,
    localparam int PU_COUNT           = PU_COUNT_PER_ROUND * GRID_WIDTH_U,
    localparam int ADDRESS_WIDTH      = (PU_COUNT > 1) ? $clog2(PU_COUNT) : 1
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire [PU_COUNT_PER_ROUND-1:0]        measurements_i,
    input  wire decoder_pkg::stage_e            global_stage_i,
    output logic [ADDRESS_WIDTH*PU_COUNT-1:0]   roots_o,
    output logic [PU_COUNT-1:0]                 busy_o,
    output logic [PU_COUNT-1:0]                 defects_o
);

    localparam int NEIGHBORS = decoder_pkg::NEIGHBOR_COUNT;

    // Bit offsets of each direction slot in a unit's root bus
    localparam int NORTH_LSB = int'(decoder_pkg::DIR_NORTH) * ADDRESS_WIDTH;
    localparam int SOUTH_LSB = int'(decoder_pkg::DIR_SOUTH) * ADDRESS_WIDTH;
    localparam int WEST_LSB  = int'(decoder_pkg::DIR_WEST) * ADDRESS_WIDTH;
    localparam int EAST_LSB  = int'(decoder_pkg::DIR_EAST) * ADDRESS_WIDTH;
    localparam int DOWN_LSB  = int'(decoder_pkg::DIR_DOWN) * ADDRESS_WIDTH;
    localparam int UP_LSB    = int'(decoder_pkg::DIR_UP) * ADDRESS_WIDTH;

    decoder_pkg::stage_e           stage_q;
    logic [PU_COUNT_PER_ROUND-1:0] measurements_q;

    // Per-unit nets, indexed by unit address
    wire                           unit_defect         [PU_COUNT];
    wire                           unit_occupied       [PU_COUNT];
    wire [ADDRESS_WIDTH-1:0]       unit_root           [PU_COUNT];
    wire [NEIGHBORS-1:0]           unit_fully_grown    [PU_COUNT];
    wire [NEIGHBORS*ADDRESS_WIDTH-1:0] unit_neighbor_roots [PU_COUNT];

    genvar k;
    genvar x;
    genvar z;

    // Stage and measurements are registered together
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= decoder_pkg::STAGE_IDLE;
        end else begin
            stage_q <= global_stage_i;
        end
    end

    always_ff @(posedge clk) begin
        measurements_q <= measurements_i;
    end

    generate
        for (k = 0; k < GRID_WIDTH_U; k = k + 1) begin : g_round
            for (x = 0; x < GRID_WIDTH_X; x = x + 1) begin : g_row
                for (z = 0; z < GRID_WIDTH_Z; z = z + 1) begin : g_col
                    localparam int IDX = k * PU_COUNT_PER_ROUND + x * GRID_WIDTH_Z + z;

                    wire local_measurement;

                    // Top round reads the input, lower rounds read the round above
                    if (k == GRID_WIDTH_U - 1) begin : g_top_round
                        assign local_measurement = measurements_q[x*GRID_WIDTH_Z + z];
                    end else begin : g_inner_round
                        assign local_measurement = unit_defect[IDX + PU_COUNT_PER_ROUND];
                    end

                    processing_unit #(
                        .ADDRESS_WIDTH (ADDRESS_WIDTH),
                        .ADDRESS       (IDX)
                    ) pu (
                        .clk                    (clk),
                        .reset                  (reset),
                        .stage_i                (stage_q),
                        .measurement_i          (local_measurement),
                        .neighbor_fully_grown_i (unit_fully_grown[IDX]),
                        .neighbor_roots_i       (unit_neighbor_roots[IDX]),
                        .defect_o               (unit_defect[IDX]),
                        .occupied_o             (unit_occupied[IDX]),
                        .root_o                 (unit_root[IDX]),
                        .busy_o                 (busy_o[IDX])
                    );

                    assign roots_o[IDX*ADDRESS_WIDTH +: ADDRESS_WIDTH] = unit_root[IDX];
                    assign defects_o[IDX] = unit_defect[IDX];

                    // North/south link to x + 1
                    if (x < GRID_WIDTH_X - 1) begin : g_ns_link
                        localparam int PEER = IDX + GRID_WIDTH_Z;
                        wire fully_grown;

                        neighbor_link #(
                            .MAX_WEIGHT (MAX_WEIGHT)
                        ) link (
                            .clk           (clk),
                            .reset         (reset),
                            .stage_i       (stage_q),
                            .a_occupied_i  (unit_occupied[IDX]),
                            .b_occupied_i  (unit_occupied[PEER]),
                            .fully_grown_o (fully_grown)
                        );

                        assign unit_fully_grown[IDX][decoder_pkg::DIR_SOUTH]  = fully_grown;
                        assign unit_fully_grown[PEER][decoder_pkg::DIR_NORTH] = fully_grown;
                        assign unit_neighbor_roots[IDX][SOUTH_LSB +: ADDRESS_WIDTH]  = unit_root[PEER];
                        assign unit_neighbor_roots[PEER][NORTH_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end else begin : g_no_south
                        assign unit_fully_grown[IDX][decoder_pkg::DIR_SOUTH] = 1'b0;
                        assign unit_neighbor_roots[IDX][SOUTH_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end

                    if (x == 0) begin : g_no_north
                        assign unit_fully_grown[IDX][decoder_pkg::DIR_NORTH] = 1'b0;
                        assign unit_neighbor_roots[IDX][NORTH_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end

                    // East/west link to z + 1
                    if (z < GRID_WIDTH_Z - 1) begin : g_ew_link
                        localparam int PEER = IDX + 1;
                        wire fully_grown;

                        neighbor_link #(
                            .MAX_WEIGHT (MAX_WEIGHT)
                        ) link (
                            .clk           (clk),
                            .reset         (reset),
                            .stage_i       (stage_q),
                            .a_occupied_i  (unit_occupied[IDX]),
                            .b_occupied_i  (unit_occupied[PEER]),
                            .fully_grown_o (fully_grown)
                        );

                        assign unit_fully_grown[IDX][decoder_pkg::DIR_EAST]  = fully_grown;
                        assign unit_fully_grown[PEER][decoder_pkg::DIR_WEST] = fully_grown;
                        assign unit_neighbor_roots[IDX][EAST_LSB +: ADDRESS_WIDTH]  = unit_root[PEER];
                        assign unit_neighbor_roots[PEER][WEST_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end else begin : g_no_east
                        assign unit_fully_grown[IDX][decoder_pkg::DIR_EAST] = 1'b0;
                        assign unit_neighbor_roots[IDX][EAST_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end

                    if (z == 0) begin : g_no_west
                        assign unit_fully_grown[IDX][decoder_pkg::DIR_WEST] = 1'b0;
                        assign unit_neighbor_roots[IDX][WEST_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end

                    // Up/down link to the next round
                    if (k < GRID_WIDTH_U - 1) begin : g_ud_link
                        localparam int PEER = IDX + PU_COUNT_PER_ROUND;
                        wire fully_grown;

                        neighbor_link #(
                            .MAX_WEIGHT (MAX_WEIGHT)
                        ) link (
                            .clk           (clk),
                            .reset         (reset),
                            .stage_i       (stage_q),
                            .a_occupied_i  (unit_occupied[IDX]),
                            .b_occupied_i  (unit_occupied[PEER]),
                            .fully_grown_o (fully_grown)
                        );

                        assign unit_fully_grown[IDX][decoder_pkg::DIR_UP]    = fully_grown;
                        assign unit_fully_grown[PEER][decoder_pkg::DIR_DOWN] = fully_grown;
                        assign unit_neighbor_roots[IDX][UP_LSB +: ADDRESS_WIDTH]    = unit_root[PEER];
                        assign unit_neighbor_roots[PEER][DOWN_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end else begin : g_no_up
                        assign unit_fully_grown[IDX][decoder_pkg::DIR_UP] = 1'b0;
                        assign unit_neighbor_roots[IDX][UP_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end

                    if (k == 0) begin : g_no_down
                        assign unit_fully_grown[IDX][decoder_pkg::DIR_DOWN] = 1'b0;
                        assign unit_neighbor_roots[IDX][DOWN_LSB +: ADDRESS_WIDTH] = unit_root[IDX];
                    end
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- testbench/graph_model.svh
`ifndef GRAPH_MODEL_SVH
`define GRAPH_MODEL_SVH

// Reference model of the decoding graph. Links are stored once, at the
// unit with the lower address, in the order south, east, up.

logic              defect_model [UNITS];
logic [ADDR_W-1:0] root_model   [UNITS];
int                link_count   [UNITS][3];

// Address of the neighbour one step along an axis, or -1 at the border
function automatic int neighbor_in(int idx, int axis);
    int x;
    int z;
    int k;
    k = idx / PER_ROUND;
    x = (idx % PER_ROUND) / GRID_Z;
    z = idx % GRID_Z;
    case (axis)
        0: return (x + 1 < GRID_X) ? idx + GRID_Z : -1;
        1: return (z + 1 < GRID_Z) ? idx + 1 : -1;
        default: return (k + 1 < GRID_U) ? idx + PER_ROUND : -1;
    endcase
endfunction

task automatic clear_model();
    for (int i = 0; i < UNITS; i++) begin
        defect_model[i] = 1'b0;
        root_model[i]   = ADDR_W'(i);
        for (int a = 0; a < 3; a++) begin
            link_count[i][a] = 0;
        end
    end
endtask

// One load cycle, ascending order reads the round above before it moves
task automatic shift_model_round(logic [PER_ROUND-1:0] meas);
    for (int i = 0; i < UNITS; i++) begin
        if (i + PER_ROUND < UNITS) begin
            defect_model[i] = defect_model[i + PER_ROUND];
        end else begin
            defect_model[i] = meas[i % PER_ROUND];
        end
        root_model[i] = ADDR_W'(i);
        for (int a = 0; a < 3; a++) begin
            link_count[i][a] = 0;
        end
    end
endtask

task automatic grow_model();
    logic occupied [UNITS];
    int   peer;
    int   sum;
    for (int i = 0; i < UNITS; i++) begin
        occupied[i] = defect_model[i];
    end
    for (int i = 0; i < UNITS; i++) begin
        for (int a = 0; a < 3; a++) begin
            peer = neighbor_in(i, a);
            if (peer >= 0 && link_count[i][a] == WEIGHT) begin
                occupied[i]    = 1'b1;
                occupied[peer] = 1'b1;
            end
        end
    end
    for (int i = 0; i < UNITS; i++) begin
        for (int a = 0; a < 3; a++) begin
            peer = neighbor_in(i, a);
            if (peer >= 0) begin
                sum = link_count[i][a] + int'(occupied[i]) + int'(occupied[peer]);
                link_count[i][a] = (sum > WEIGHT) ? WEIGHT : sum;
            end
        end
    end
endtask

// Spread the smallest root over each component of fully grown links
task automatic merge_model_roots();
    bit changed;
    int peer;
    changed = 1'b1;
    while (changed) begin
        changed = 1'b0;
        for (int i = 0; i < UNITS; i++) begin
            for (int a = 0; a < 3; a++) begin
                peer = neighbor_in(i, a);
                if (peer >= 0 && link_count[i][a] == WEIGHT) begin
                    if (root_model[peer] < root_model[i]) begin
                        root_model[i] = root_model[peer];
                        changed = 1'b1;
                    end else if (root_model[i] < root_model[peer]) begin
                        root_model[peer] = root_model[i];
                        changed = 1'b1;
                    end
                end
            end
        end
    end
endtask

`endif

//--- testbench/decoding_graph_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decoding_graph_tb;

    localparam int GRID_X         = 3;
    localparam int GRID_Z         = 2;
    localparam int GRID_U         = 3;
    localparam int WEIGHT         = 2;
    localparam int PER_ROUND      = GRID_X * GRID_Z;
    localparam int UNITS          = PER_ROUND * GRID_U;
    localparam int ADDR_W         = $clog2(UNITS);
    localparam int MERGE_LIMIT    = 2 * UNITS; // Longest path in the grid is shorter
    localparam int TIMEOUT_CYCLES = 3000; // All tests take a few hundred cycles

    logic                       clk;
    logic                       reset;
    logic [PER_ROUND-1:0]       measurements_i;
    decoder_pkg::stage_e        global_stage_i;
    logic [ADDR_W*UNITS-1:0]    roots_o;
    logic [UNITS-1:0]           busy_o;
    logic [UNITS-1:0]           defects_o;

    logic [31:0] lfsr_state = 32'hacde430c;
    int          cycle_count = 0;

    `include "graph_model.svh"

    decoding_graph #(
        .GRID_WIDTH_X (GRID_X),
        .GRID_WIDTH_Z (GRID_Z),
        .GRID_WIDTH_U (GRID_U),
        .MAX_WEIGHT   (WEIGHT)
    ) decoding_graph_i (
        .clk            (clk),
        .reset          (reset),
        .measurements_i (measurements_i),
        .global_stage_i (global_stage_i),
        .roots_o        (roots_o),
        .busy_o         (busy_o),
        .defects_o      (defects_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic next_lfsr_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    task automatic check_root(string name, logic [ADDR_W-1:0] actual, logic [ADDR_W-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_stage(string name, decoder_pkg::stage_e actual,
                               decoder_pkg::stage_e expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    // Drive one cycle, then confirm the stage register took the code
    task automatic drive_cycle(decoder_pkg::stage_e stage, logic [PER_ROUND-1:0] meas);
        global_stage_i = stage;
        measurements_i = meas;
        @(posedge clk);
        #10;
        check_stage("stage_q", decoding_graph_i.stage_q, stage);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) drive_cycle(decoder_pkg::STAGE_IDLE, '0);
    endtask

    // Round 0 of the syndrome is driven first and ends up at the bottom
    task automatic load_syndrome(logic [UNITS-1:0] syndrome);
        for (int k = 0; k < GRID_U; k++) begin
            drive_cycle(decoder_pkg::STAGE_LOAD, syndrome[k*PER_ROUND +: PER_ROUND]);
            shift_model_round(syndrome[k*PER_ROUND +: PER_ROUND]);
        end
        idle_cycles(2);
    endtask

    task automatic grow_cycles(int n);
        repeat (n) begin
            drive_cycle(decoder_pkg::STAGE_GROW, '0);
            grow_model();
        end
        idle_cycles(2);
    endtask

    // Busy reflects the first merge step two cycles after the drive
    task automatic merge_until_settled();
        int cycles;
        cycles = 0;
        drive_cycle(decoder_pkg::STAGE_MERGE, '0);
        drive_cycle(decoder_pkg::STAGE_MERGE, '0);
        while (busy_o != '0) begin
            if (cycles >= MERGE_LIMIT) begin
                $display("Merge did not settle within %0d cycles", MERGE_LIMIT);
                abort_run();
            end
            drive_cycle(decoder_pkg::STAGE_MERGE, '0);
            cycles++;
        end
        idle_cycles(2);
        merge_model_roots();
    endtask

    task automatic merge_quiet(int n);
        repeat (n) begin
            drive_cycle(decoder_pkg::STAGE_MERGE, '0);
            for (int i = 0; i < UNITS; i++) begin
                check_bit($sformatf("busy_o[%0d]", i), busy_o[i], 1'b0);
            end
        end
        idle_cycles(2);
        merge_model_roots();
    endtask

    task automatic compare_with_model();
        for (int i = 0; i < UNITS; i++) begin
            check_root($sformatf("roots_o[%0d]", i), roots_o[i*ADDR_W +: ADDR_W], root_model[i]);
            check_bit($sformatf("defects_o[%0d]", i), defects_o[i], defect_model[i]);
            check_bit($sformatf("busy_o[%0d]", i), busy_o[i], 1'b0);
        end
    endtask

    task automatic test_reset();
        idle_cycles(2);
        compare_with_model();
    endtask

    task automatic test_loading();
        load_syndrome({6'b011000, 6'b110010, 6'b000101});
        compare_with_model();
    endtask

    task automatic test_isolated_defects();
        logic [UNITS-1:0] syndrome;
        syndrome     = '0;
        syndrome[0]  = 1'b1; // Bottom round, first corner
        syndrome[17] = 1'b1; // Top round, far corner
        load_syndrome(syndrome);
        grow_cycles(1);
        merge_quiet(10);
        compare_with_model();
    endtask

    task automatic test_adjacent_merge();
        logic [UNITS-1:0] syndrome;
        syndrome     = '0;
        syndrome[8]  = 1'b1; // Middle round, x = 1
        syndrome[10] = 1'b1; // Middle round, x = 2
        load_syndrome(syndrome);
        grow_cycles(WEIGHT);
        merge_until_settled();
        compare_with_model();
    endtask

    task automatic test_random_syndromes();
        logic [UNITS-1:0] syndrome;
        int               grow_count;
        repeat (8) begin
            for (int i = 0; i < UNITS; i++) begin
                syndrome[i] = next_lfsr_bit() & next_lfsr_bit(); // Sparse defects
            end
            grow_count = 1 + ((2 * int'(next_lfsr_bit()) + int'(next_lfsr_bit())) % 3);
            load_syndrome(syndrome);
            grow_cycles(grow_count);
            merge_until_settled();
            compare_with_model();
        end
    endtask

    task automatic test_reload();
        load_syndrome('0);
        compare_with_model();
        merge_quiet(10);
        compare_with_model();
    endtask

    initial begin
        reset          = 1'b1;
        measurements_i = '0;
        global_stage_i = decoder_pkg::STAGE_IDLE;
        clear_model();
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        test_reset();
        test_loading();
        test_isolated_defects();
        test_adjacent_merge();
        test_random_syndromes();
        test_reload();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+testbench
hw/decoder_pkg.sv
hw/neighbor_link.sv
hw/processing_unit.sv
hw/decoding_graph.sv
testbench/decoding_graph_tb.sv
